// ==== compile.f ====
source/rst_pkg.sv
source/key_checker.sv
source/table_rotor.sv
source/substitution_unit.sv
source/rst_cipher.sv
+incdir+tests
tests/rst_cipher_tb.sv

// ==== source/key_checker.sv ====
// registers the cipher key and checks that it holds twelve distinct alphanumeric characters
`timescale 1ns/10ps

module key_checker (
  input  logic          clk,
  input  logic          rst_n,
  input  rst_pkg::key_t key,
  output rst_pkg::key_t key_q,
  output logic          key_ok,
  output logic          err_invalid_key
);

  import rst_pkg::*;

  logic all_alnum;
  logic has_repeat;

  // key is sampled every cycle, verdict follows one edge later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_q <= '0;
    end else begin
      key_q <= key;
    end
  end

  // character class of every position
  always_comb begin
    all_alnum = 1'b1;
    for (int i = 0; i < KEY_LEN; i++) begin
      if (!char_is_alnum(key_q[i])) begin
        all_alnum = 1'b0;
      end
    end
  end

  // pairwise compare, each pair once
  always_comb begin
    has_repeat = 1'b0;
    for (int i = 0; i < KEY_LEN - 1; i++) begin
      for (int j = i + 1; j < KEY_LEN; j++) begin
        if (key_q[i] == key_q[j]) begin
          has_repeat = 1'b1;
        end
      end
    end
  end

  assign key_ok = all_alnum && !has_repeat;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_invalid_key <= 1'b0;
    end else begin
      err_invalid_key <= !key_ok;
    end
  end

endmodule

// ==== source/rst_cipher.sv ====
// top level of the rotary substitution cipher, wiring key check, table and substitution together
`timescale 1ns/10ps

module rst_cipher (
  input  logic           clk,
  input  logic           rst_n,
  input  rst_pkg::key_t  key,
  input  logic           ptxt_valid,
  input  rst_pkg::char_t ptxt_char,
  output rst_pkg::ctxt_t ctxt_str,
  output logic           ctxt_ready,
  output logic           err_invalid_ptxt_char,
  output logic           err_invalid_key,
  output logic           key_not_installed
);

  import rst_pkg::*;

  key_t       key_q;
  logic       key_ok;
  rot_table_t rot_table;
  logic       installed;
  // substitution feedback that steps the table
  logic       hit;

  key_checker u_key_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .key             (key),
    .key_q           (key_q),
    .key_ok          (key_ok),
    .err_invalid_key (err_invalid_key)
  );

  table_rotor u_table_rotor (
    .clk               (clk),
    .rst_n             (rst_n),
    .key_q             (key_q),
    .key_ok            (key_ok),
    .hit               (hit),
    .rot_table         (rot_table),
    .installed         (installed),
    .key_not_installed (key_not_installed)
  );

  substitution_unit u_substitution_unit (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .ptxt_valid            (ptxt_valid),
    .ptxt_char             (ptxt_char),
    .rot_table             (rot_table),
    .installed             (installed),
    .hit                   (hit),
    .ctxt_str              (ctxt_str),
    .ctxt_ready            (ctxt_ready),
    .err_invalid_ptxt_char (err_invalid_ptxt_char)
  );

endmodule

// ==== source/rst_pkg.sv ====
// shared types, constants and character helpers for the rotary substitution cipher; import in each module
package rst_pkg;

  // one ascii character
  typedef logic [7:0] char_t;

  localparam int KEY_LEN   = 12;
  localparam int TABLE_DIM = 6;

  // key position 0 is the lowest character
  typedef char_t [KEY_LEN-1:0] key_t;

  // one line of the table, entry 0 at the bottom
  typedef char_t [TABLE_DIM-1:0] line_t;

  typedef struct packed {
    line_t rows;
    line_t cols;
  } rot_table_t;

  // row character goes out in the upper byte
  typedef struct packed {
    char_t row_char;
    char_t col_char;
  } ctxt_t;

  // 0..25 letters, 26..35 digits
  typedef logic [5:0] sym_idx_t;

  localparam char_t NUL_CHAR = 8'h00;

  // ascii class bounds
  localparam char_t UPPER_A = 8'h41;
  localparam char_t UPPER_Z = 8'h5a;
  localparam char_t LOWER_A = 8'h61;
  localparam char_t LOWER_Z = 8'h7a;
  localparam char_t DIGIT_0 = 8'h30;
  localparam char_t DIGIT_9 = 8'h39;

  localparam sym_idx_t DIGIT_BASE = 6'd26;

  function automatic logic char_is_upper(input char_t ch);
    return (ch >= UPPER_A) && (ch <= UPPER_Z);
  endfunction

  function automatic logic char_is_lower(input char_t ch);
    return (ch >= LOWER_A) && (ch <= LOWER_Z);
  endfunction

  function automatic logic char_is_digit(input char_t ch);
    return (ch >= DIGIT_0) && (ch <= DIGIT_9);
  endfunction

  // letter or digit, the only characters the cipher accepts
  function automatic logic char_is_alnum(input char_t ch);
    return char_is_upper(ch) || char_is_lower(ch) || char_is_digit(ch);
  endfunction

  // case is ignored, so A and a share index 0
  // only meaningful for alphanumeric input
  function automatic sym_idx_t char_sym_idx(input char_t ch);
    char_t    offs;
    sym_idx_t idx;
    offs = '0;
    idx  = '0;
    if (char_is_upper(ch)) begin
      offs = ch - UPPER_A;
      idx  = sym_idx_t'(offs);
    end else if (char_is_lower(ch)) begin
      offs = ch - LOWER_A;
      idx  = sym_idx_t'(offs);
    end else if (char_is_digit(ch)) begin
      offs = ch - DIGIT_0;
      idx  = sym_idx_t'(offs) + DIGIT_BASE;
    end
    return idx;
  endfunction

endpackage

// ==== source/substitution_unit.sv ====
// registers a strobed plaintext character and maps it to a row and column character pair
`timescale 1ns/10ps

module substitution_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ptxt_valid,
  input  rst_pkg::char_t      ptxt_char,
  input  rst_pkg::rot_table_t rot_table,
  input  logic                installed,
  output logic                hit,
  output rst_pkg::ctxt_t      ctxt_str,
  output logic                ctxt_ready,
  output logic                err_invalid_ptxt_char
);

  import rst_pkg::*;

  localparam int SEL_W = $clog2(TABLE_DIM);

  logic             ptxt_valid_q;
  char_t            ptxt_char_q;
  logic             char_ok;
  logic             bad_char;
  sym_idx_t         sym_idx;
  logic [SEL_W-1:0] row_sel;
  logic [SEL_W-1:0] col_sel;
  ctxt_t            ctxt_pair;

  // input stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptxt_valid_q <= 1'b0;
    end else begin
      ptxt_valid_q <= ptxt_valid;
    end
  end

  always_ff @(posedge clk) begin
    ptxt_char_q <= ptxt_char;
  end

  assign char_ok = char_is_alnum(ptxt_char_q);

  // nothing is reported before a table exists
  assign hit      = ptxt_valid_q && char_ok && installed;
  assign bad_char = ptxt_valid_q && !char_ok && installed;

  // index 0..35 folds onto a 6x6 grid
  assign sym_idx = char_sym_idx(ptxt_char_q);
  assign row_sel = SEL_W'(sym_idx / TABLE_DIM);
  assign col_sel = SEL_W'(sym_idx % TABLE_DIM);

  assign ctxt_pair.row_char = rot_table.rows[row_sel];
  assign ctxt_pair.col_char = rot_table.cols[col_sel];

  // output stage, NUL pair when idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctxt_str              <= '{row_char: NUL_CHAR, col_char: NUL_CHAR};
      ctxt_ready            <= 1'b0;
      err_invalid_ptxt_char <= 1'b0;
    end else begin
      ctxt_ready            <= hit;
      err_invalid_ptxt_char <= bad_char;
      if (hit) begin
        ctxt_str <= ctxt_pair;
      end else begin
        ctxt_str <= '{row_char: NUL_CHAR, col_char: NUL_CHAR};
      end
    end
  end

  a_ready_err_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ctxt_ready && err_invalid_ptxt_char)
  ) else $error("ctxt_ready and err_invalid_ptxt_char high together");

  // key_not_installed is installed delayed by one edge and inverted,
  // so an output pulse needs installed one edge earlier
  a_quiet_before_install: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ctxt_ready || err_invalid_ptxt_char) |-> $past(installed)
  ) else $error("output pulse while key not installed");

endmodule

// ==== source/table_rotor.sv ====
// holds the row and column sets, loads them from the first valid key and rotates them on each hit
`timescale 1ns/10ps

module table_rotor (
  input  logic                clk,
  input  logic                rst_n,
  input  rst_pkg::key_t       key_q,
  input  logic                key_ok,
  input  logic                hit,
  output rst_pkg::rot_table_t rot_table,
  output logic                installed,
  output logic                key_not_installed
);

  import rst_pkg::*;

  rot_table_t install_table;
  rot_table_t rotated_table;
  logic       do_install;

  // odd key positions fill the rows, even ones the columns
  always_comb begin
    install_table.rows[0] = key_q[11];
    install_table.rows[1] = key_q[1];
    install_table.rows[2] = key_q[9];
    install_table.rows[3] = key_q[3];
    install_table.rows[4] = key_q[7];
    install_table.rows[5] = key_q[5];
    install_table.cols[0] = key_q[10];
    install_table.cols[1] = key_q[0];
    install_table.cols[2] = key_q[8];
    install_table.cols[3] = key_q[2];
    install_table.cols[4] = key_q[6];
    install_table.cols[5] = key_q[4];
  end

  // one step up, the top entry wraps to position 0
  assign rotated_table.rows = {rot_table.rows[TABLE_DIM-2:0],
                               rot_table.rows[TABLE_DIM-1]};
  assign rotated_table.cols = {rot_table.cols[TABLE_DIM-2:0],
                               rot_table.cols[TABLE_DIM-1]};

  // only the first valid key after reset is taken
  assign do_install = !installed && key_ok;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      installed         <= 1'b0;
      key_not_installed <= 1'b0;
    end else begin
      if (do_install) begin
        installed <= 1'b1;
      end
      key_not_installed <= !installed;
    end
  end

  // hit is already qualified by installed
  always_ff @(posedge clk) begin
    if (do_install) begin
      rot_table <= install_table;
    end else if (hit) begin
      rot_table <= rotated_table;
    end
  end

  // table only moves when a character is substituted
  a_table_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (installed && !hit) |=> $stable(rot_table)
  ) else $error("table changed without a substitution");

endmodule

// ==== tests/rst_model.svh ====
// reference model of the cipher table plus compare tasks, included inside the testbench module
`ifndef RST_MODEL_SVH
`define RST_MODEL_SVH

rot_table_t model_table;
logic       model_installed;
int         error_count;

function automatic void reset_model();
  model_table     = '0;
  model_installed = 1'b0;
endfunction

function automatic logic is_letter_or_digit(input char_t ch);
  return (ch >= "A" && ch <= "Z") || (ch >= "a" && ch <= "z") || (ch >= "0" && ch <= "9");
endfunction

// letters 0..25 without case, digits 26..35
function automatic int symbol_index(input char_t ch);
  if (ch >= "A" && ch <= "Z") begin
    return ch - "A";
  end else if (ch >= "a" && ch <= "z") begin
    return ch - "a";
  end
  return ch - "0" + 26;
endfunction

// rows from odd key positions, columns from even ones
function automatic void install_table(input key_t k);
  int row_pos [TABLE_DIM];
  int col_pos [TABLE_DIM];
  row_pos = '{11, 1, 9, 3, 7, 5};
  col_pos = '{10, 0, 8, 2, 6, 4};
  for (int i = 0; i < TABLE_DIM; i++) begin
    model_table.rows[i] = k[row_pos[i]];
    model_table.cols[i] = k[col_pos[i]];
  end
  model_installed = 1'b1;
endfunction

// new entry i is old entry i-1, old entry 5 wraps to 0
function automatic void rotate_table();
  rot_table_t old;
  old = model_table;
  for (int i = 0; i < TABLE_DIM; i++) begin
    model_table.rows[i] = old.rows[(i + TABLE_DIM - 1) % TABLE_DIM];
    model_table.cols[i] = old.cols[(i + TABLE_DIM - 1) % TABLE_DIM];
  end
endfunction

function automatic ctxt_t encrypt_char(input char_t ch);
  int    idx;
  ctxt_t pair;
  idx           = symbol_index(ch);
  pair.row_char = model_table.rows[idx / TABLE_DIM];
  pair.col_char = model_table.cols[idx % TABLE_DIM];
  rotate_table();
  return pair;
endfunction

task automatic check_ctxt(input string name, input ctxt_t exp, input ctxt_t act);
  if (act !== exp) begin
    $display("Fail %s expected %h got %h", name, exp, act);
    error_count++;
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("Fail %s expected %h got %h", name, exp, act);
    error_count++;
  end
endtask

`endif

// ==== tests/rst_cipher_tb.sv ====
// directed testbench for the rotary substitution cipher, compiled from compile.f with top rst_cipher_tb
`timescale 1ns/10ps

module rst_cipher_tb;

  import rst_pkg::*;

  `include "rst_model.svh"

  localparam key_t KEY_A   = "K7pQ2xMa9Zt4";
  localparam key_t KEY_B   = "Hn3Wd8Rc1Ye6";
  localparam key_t KEY_DUP = "AbCdEfGhAjKl";
  localparam key_t KEY_SYM = "Abc#efGhiJk1";

  localparam int INSTALL_WAIT = 8;
  // cycle budget of each test in run order
  localparam int RUN_CYCLES  = 12 + 24 + 40 + 24 + 50 + 30;
  localparam int WATCHDOG_NS = RUN_CYCLES * 10 + 1000;

  typedef enum logic [1:0] {EXP_IDLE, EXP_CTXT, EXP_BAD} exp_kind_t;

  typedef struct packed {
    exp_kind_t kind;
    char_t     ch;
    ctxt_t     ctxt;
  } expect_t;

  logic   clk;
  logic   rst_n;
  key_t   key;
  logic   ptxt_valid;
  char_t  ptxt_char;
  ctxt_t  ctxt_str;
  logic   ctxt_ready;
  logic   err_invalid_ptxt_char;
  logic   err_invalid_key;
  logic   key_not_installed;

  expect_t pending[$];
  ctxt_t   captured[$];
  int      tests_run;
  int      tests_ok;
  int      tests_bad;

  rst_cipher u_dut (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .key                   (key),
    .ptxt_valid            (ptxt_valid),
    .ptxt_char             (ptxt_char),
    .ctxt_str              (ctxt_str),
    .ctxt_ready            (ctxt_ready),
    .err_invalid_ptxt_char (err_invalid_ptxt_char),
    .err_invalid_key       (err_invalid_key),
    .key_not_installed     (key_not_installed)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

  task automatic check_ready(input logic exp, input char_t ch);
    if (ctxt_ready !== exp) begin
      if (exp) begin
        $display("ctxt_ready missing for character %h", ch);
      end else begin
        $display("unexpected ctxt_ready pulse");
      end
      error_count++;
    end
  endtask

  task automatic apply_reset();
    rst_n      = 1'b0;
    key        = '0;
    ptxt_valid = 1'b0;
    ptxt_char  = NUL_CHAR;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_model();
    pending.delete();
  endtask

  task automatic install_key(input key_t k);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    key = k;
    @(negedge clk);
    while (key_not_installed !== 1'b0 && waited < INSTALL_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (key_not_installed !== 1'b0) begin
      $display("key was not installed within %0d cycles", INSTALL_WAIT);
      error_count++;
    end
    install_table(k);
  endtask

  function automatic expect_t predict(input logic valid, input char_t ch);
    expect_t e;
    e.kind          = EXP_IDLE;
    e.ch            = ch;
    e.ctxt.row_char = NUL_CHAR;
    e.ctxt.col_char = NUL_CHAR;
    if (valid && model_installed) begin
      if (is_letter_or_digit(ch)) begin
        e.kind = EXP_CTXT;
        e.ctxt = encrypt_char(ch);
      end else begin
        e.kind = EXP_BAD;
      end
    end
    return e;
  endfunction

  task automatic verify_cycle(input expect_t e);
    ctxt_t exp_ctxt;
    exp_ctxt.row_char = NUL_CHAR;
    exp_ctxt.col_char = NUL_CHAR;
    if (e.kind == EXP_CTXT) begin
      exp_ctxt = e.ctxt;
    end
    check_ready(e.kind == EXP_CTXT, e.ch);
    check_flag("err_invalid_ptxt_char", e.kind == EXP_BAD, err_invalid_ptxt_char);
    check_ctxt("ctxt_str", exp_ctxt, ctxt_str);
    if (ctxt_ready === 1'b1) begin
      captured.push_back(ctxt_str);
    end
  endtask

  // a drive shows up at the negedge two cycles later
  task automatic cycle_step(input logic valid, input char_t ch);
    @(posedge clk);
    #1;
    ptxt_valid = valid;
    ptxt_char  = ch;
    pending.push_back(predict(valid, ch));
    @(negedge clk);
    if (pending.size() > 2) begin
      verify_cycle(pending.pop_front());
    end
  endtask

  task automatic flush_pipeline();
    repeat (2) cycle_step(1'b0, NUL_CHAR);
    pending.delete();
  endtask

  function automatic char_t random_alnum();
    string alnum;
    alnum = "ABCDEFGHIJKLMNOPQRSTUVWXYZabcdefghijklmnopqrstuvwxyz0123456789";
    return alnum[$urandom % alnum.len()];
  endfunction

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (error_count == start_errors) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", name, error_count - start_errors);
    end
  endtask

  task automatic reset_and_install();
    int start;
    start = error_count;
    apply_reset();
    @(negedge clk);
    check_ready(1'b0, NUL_CHAR);
    check_flag("err_invalid_ptxt_char", 1'b0, err_invalid_ptxt_char);
    check_flag("err_invalid_key", 1'b0, err_invalid_key);
    check_flag("key_not_installed", 1'b0, key_not_installed);
    check_ctxt("ctxt_str", '0, ctxt_str);
    @(negedge clk);
    check_flag("key_not_installed", 1'b1, key_not_installed);
    @(posedge clk);
    #1;
    key = KEY_A;
    // sampled at k, verdict at k+1, flag falls at k+2
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_flag("err_invalid_key", 1'b0, err_invalid_key);
    check_flag("key_not_installed", 1'b1, key_not_installed);
    @(negedge clk);
    check_flag("err_invalid_key", 1'b0, err_invalid_key);
    check_flag("key_not_installed", 1'b0, key_not_installed);
    install_table(KEY_A);
    finish_test("reset_and_install", start);
  endtask

  task automatic bad_key(input key_t k);
    @(posedge clk);
    #1;
    key = k;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_flag("err_invalid_key", 1'b1, err_invalid_key);
    check_flag("key_not_installed", 1'b1, key_not_installed);
  endtask

  task automatic invalid_keys();
    int start;
    start = error_count;
    apply_reset();
    bad_key(KEY_DUP);
    bad_key(KEY_SYM);
    cycle_step(1'b1, "A");
    cycle_step(1'b1, "m");
    cycle_step(1'b1, "!");
    cycle_step(1'b1, "5");
    flush_pipeline();
    check_flag("key_not_installed", 1'b1, key_not_installed);
    finish_test("invalid_keys", start);
  endtask

  task automatic fixed_string();
    int         start;
    string      msg;
    rot_table_t saved;
    ctxt_t      exp_upper;
    start = error_count;
    msg   = "Q3mZk7qT0bW9";
    install_key(KEY_A);
    captured.delete();
    // uppercase prediction for the layout the first character meets
    saved       = model_table;
    exp_upper   = encrypt_char("Q");
    model_table = saved;
    for (int i = 0; i < msg.len(); i++) begin
      cycle_step(1'b1, msg[i]);
      cycle_step(1'b0, NUL_CHAR);
    end
    flush_pipeline();
    // six rotations bring the table back for the lowercase q
    if (captured.size() < 7) begin
      $display("only %0d ciphertext pairs seen for the fixed string", captured.size());
      error_count++;
    end else begin
      check_ctxt("ctxt_str of q", exp_upper, captured[6]);
    end
    finish_test("fixed_string", start);
  endtask

  task automatic invalid_plaintext();
    int start;
    start = error_count;
    cycle_step(1'b1, "K");
    cycle_step(1'b0, NUL_CHAR);
    cycle_step(1'b1, "#");
    cycle_step(1'b0, NUL_CHAR);
    cycle_step(1'b1, "K");
    cycle_step(1'b1, "!");
    cycle_step(1'b1, "b");
    cycle_step(1'b1, "?");
    cycle_step(1'b1, "z");
    flush_pipeline();
    finish_test("invalid_plaintext", start);
  endtask

  task automatic back_to_back();
    int start;
    start = error_count;
    repeat (40) cycle_step(1'b1, random_alnum());
    flush_pipeline();
    finish_test("back_to_back", start);
  endtask

  task automatic key_change();
    int start;
    start = error_count;
    @(posedge clk);
    #1;
    key = KEY_B;
    // model keeps the original table
    repeat (12) cycle_step(1'b1, random_alnum());
    flush_pipeline();
    check_flag("err_invalid_key", 1'b0, err_invalid_key);
    check_flag("key_not_installed", 1'b0, key_not_installed);
    finish_test("key_change", start);
  endtask

  initial begin
    rst_n       = 1'b0;
    key         = '0;
    ptxt_valid  = 1'b0;
    ptxt_char   = NUL_CHAR;
    error_count = 0;
    tests_run   = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    void'($urandom(32'h0418568c));
    reset_model();
    reset_and_install();
    invalid_keys();
    fixed_string();
    invalid_plaintext();
    back_to_back();
    key_change();
    $display("%0d tests run, %0d ok, %0d with errors", tests_run, tests_ok, tests_bad);
    if (tests_bad == 0 && error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
